// ==== filelist.f ====
+incdir+logic
logic/npu_pkg.sv
logic/npu_buffer.sv
logic/npu_index_counter.sv
logic/npu_mac_unit.sv
logic/npu_activation.sv
logic/npu_reg_bank.sv
logic/npu_seq_fsm.sv
logic/npu_top.sv
verif/npu_properties.sv
verif/npu_tb.sv

// ==== Makefile ====
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	rm -f $(LOG)
	verilator --binary --timing --assert -Wno-fatal --top-module npu_tb \
		-f filelist.f -o npu_sim
	./obj_dir/npu_sim | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== verif/npu_tb.sv ====
// npu testbench
// loads operands over the register bus, runs a table of matrix-vector
// products and checks every output against a reference model
`timescale 1ns/10ps
`include "npu_settings.svh"

module npu_tb;

    localparam int n_tests = 6;
    localparam int dim     = `NPU_DIM;
    // cycles from the start write to the rising done flag
    localparam int run_latency = 67;

    logic        aclk;
    logic        rst_n;
    logic        reg_wr;
    logic        reg_rd;
    logic [7:0]  reg_addr;
    logic [15:0] reg_wdata;
    logic [15:0] reg_rdata;
    logic        reg_rvalid;
    logic        interrupt;

    // ============================================================
    // stimulus table
    // ============================================================
    // activation, identity weights, operand mask, second start while busy
    string       test_name  [n_tests] = '{"identity weights", "relu small", "overflow identity",
                                          "step", "spare type", "restart while busy"};
    logic [1:0]  test_act   [n_tests] = '{2'd0, 2'd1, 2'd0, 2'd2, 2'd3, 2'd0};
    logic        test_ident [n_tests] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    logic [15:0] test_mask  [n_tests] = '{16'hffff, 16'h01ff, 16'h7fff, 16'h03ff,
                                          16'h03ff, 16'h00ff};
    logic        test_again [n_tests] = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b1};

    logic [31:0] lcg_state = 32'hf6ec_7b98;
    logic [15:0] in_vec   [dim];
    logic [15:0] wt_mat   [dim*dim];
    logic [15:0] expected [dim];
    int          errors;
    int          passed;
    int          failed;
    logic        timed_out;
    int          cycle_count = 0;

    always #5 aclk = ~aclk;

    // rising edges seen so far
    always @(posedge aclk) cycle_count++;

    npu_top i_npu_top (
        .aclk       (aclk),
        .rst_n      (rst_n),
        .reg_wr     (reg_wr),
        .reg_rd     (reg_rd),
        .reg_addr   (reg_addr),
        .reg_wdata  (reg_wdata),
        .reg_rdata  (reg_rdata),
        .reg_rvalid (reg_rvalid),
        .interrupt  (interrupt)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    // magnitude bounded by the mask, sign from the top bit
    function automatic logic [15:0] random_operand(input logic [15:0] mask);
        logic [31:0] r;
        logic [15:0] mag;
        r   = next_random();
        mag = r[23:8] & mask;
        return r[31] ? -mag : mag;
    endfunction

    // reference activation, then Q8.8 reduction with saturation
    function automatic logic [15:0] apply_activation(input logic [31:0] sum,
                                                     input logic [1:0] act);
        logic [31:0] v;
        v = sum;
        if (act == 2'd1 && sum[31]) begin
            v = 32'h0;
        end else if (act == 2'd2) begin
            v = (!sum[31] && sum != 32'h0) ? 32'h0001_0000 : 32'h0;
        end
        if (v[31:24] != {8{v[23]}}) begin
            return v[31] ? 16'h8000 : 16'h7fff;
        end
        return v[23:8];
    endfunction

    task automatic check_equal(input string sig, input logic [15:0] exp_val,
                               input logic [15:0] got_val);
        assert (got_val === exp_val) else begin
            $display("FAIL t=%0t %s expected %h got %h", $time, sig, exp_val, got_val);
            errors++;
        end
    endtask

    // ============================================================
    // bus access, called on a falling edge
    // ============================================================
    task automatic bus_write(input logic [7:0] addr, input logic [15:0] data);
        reg_wr    = 1'b1;
        reg_addr  = addr;
        reg_wdata = data;
        @(negedge aclk);
        reg_wr = 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] addr, output logic [15:0] data);
        int n;
        reg_rd   = 1'b1;
        reg_addr = addr;
        @(negedge aclk);
        reg_rd = 1'b0;
        for (n = 0; n < 4 && !reg_rvalid; n++) begin
            @(negedge aclk);
        end
        if (!reg_rvalid) begin
            $display("read of address %h returned no rvalid within 4 cycles", addr);
            errors++;
            timed_out = 1'b1;
        end
        data = reg_rdata;
    endtask

    task automatic wait_interrupt();
        int cycles;
        cycles = 0;
        while (!interrupt && cycles < 200) begin
            @(negedge aclk);
            cycles++;
        end
        if (!interrupt) begin
            $display("interrupt did not rise within 200 cycles of the start");
            errors++;
            timed_out = 1'b1;
        end
    endtask

    // ============================================================
    // operands and reference model
    // ============================================================
    task automatic load_operands(input int idx);
        int j;
        int k;
        for (j = 0; j < dim; j++) begin
            in_vec[j] = random_operand(test_mask[idx]);
            bus_write(`NPU_BASE_INPUT + 8'(j), in_vec[j]);
        end
        for (k = 0; k < dim * dim; k++) begin
            if (test_ident[idx]) begin
                wt_mat[k] = (k / dim == k % dim) ? 16'h0100 : 16'h0000;
            end else begin
                wt_mat[k] = random_operand(test_mask[idx]);
            end
            bus_write(`NPU_BASE_WEIGHT + 8'(k), wt_mat[k]);
        end
    endtask

    task automatic compute_expected(input logic [1:0] act);
        logic signed [31:0] sum;
        logic signed [31:0] prod;
        int i;
        int j;
        for (i = 0; i < dim; i++) begin
            sum = 32'sh0;
            for (j = 0; j < dim; j++) begin
                prod = 32'($signed(wt_mat[i*dim+j])) * 32'($signed(in_vec[j]));
                sum  = sum + prod;
            end
            expected[i] = apply_activation(sum, act);
        end
    endtask

    task automatic run_entry(input int idx);
        logic [15:0] got;
        logic        had_done;
        int          start_cycle;
        int          i;
        load_operands(idx);
        compute_expected(test_act[idx]);
        had_done    = interrupt;
        start_cycle = cycle_count;
        bus_write(`NPU_ADDR_CTRL, {13'b0, test_act[idx], 1'b1});
        // a new start clears the previous done
        if (had_done) begin
            check_equal("interrupt", 16'h0000, {15'b0, interrupt});
        end
        if (test_again[idx]) begin
            repeat (8) @(negedge aclk);
            bus_read(`NPU_ADDR_STATUS, got);
            check_equal("status", 16'h0001, got);
            // different activation, must not reach this run
            bus_write(`NPU_ADDR_CTRL, {13'b0, test_act[idx] ^ 2'd2, 1'b1});
        end
        wait_interrupt();
        if (!timed_out) begin
            check_equal("done latency", 16'(run_latency), 16'(cycle_count - start_cycle));
            bus_read(`NPU_ADDR_STATUS, got);
            check_equal("status", 16'h0002, got);
            for (i = 0; i < dim; i++) begin
                bus_read(`NPU_BASE_OUTPUT + 8'(i), got);
                check_equal($sformatf("out[%0d]", i), expected[i], got);
                if (test_ident[idx]) begin
                    check_equal($sformatf("out[%0d] vs input", i), in_vec[i], got);
                end
            end
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        if (errors == err_before) begin
            passed++;
            $display("test %s: passed", name);
        end else begin
            failed++;
            $display("test %s: failed with %0d errors", name, errors - err_before);
        end
    endtask

    // ============================================================
    // main sequence
    // ============================================================
    initial begin
        logic [15:0] got;
        int          err_before;
        int          t;
        aclk      = 1'b0;
        rst_n     = 1'b0;
        reg_wr    = 1'b0;
        reg_rd    = 1'b0;
        reg_addr  = 8'h00;
        reg_wdata = 16'h0000;
        errors    = 0;
        passed    = 0;
        failed    = 0;
        timed_out = 1'b0;
        repeat (5) @(negedge aclk);
        rst_n = 1'b1;

        err_before = errors;
        check_equal("reg_rvalid", 16'h0000, {15'b0, reg_rvalid});
        bus_read(`NPU_ADDR_STATUS, got);
        check_equal("status", 16'h0000, got);
        check_equal("interrupt", 16'h0000, {15'b0, interrupt});
        report_test("reset state", err_before);

        for (t = 0; t < n_tests && !timed_out; t++) begin
            err_before = errors;
            run_entry(t);
            report_test(test_name[t], err_before);
        end

        $display("tests passed %0d failed %0d errors %0d", passed, failed, errors);
        if (errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== verif/npu_properties.sv ====
// run sequencer properties
// checks busy after reset, the run_done pulse and output writes
`timescale 1ns/10ps

module npu_properties (
    input logic                aclk,
    input logic                rst_n,
    input npu_pkg::seq_state_t state,
    input logic                busy,
    input logic                run_done,
    input logic                out_wr_en
);
    import npu_pkg::*;

    // any reset cycle leaves the sequencer idle
    busy_after_reset: assert property (@(posedge aclk) !rst_n |=> !busy)
        else $error("busy high in the cycle after reset");

    done_single_pulse: assert property (@(posedge aclk) disable iff (!rst_n)
        run_done |=> !run_done)
        else $error("run_done held for more than one cycle");

    write_while_active: assert property (@(posedge aclk) disable iff (!rst_n)
        out_wr_en |-> state != seq_idle)
        else $error("output buffer written while the sequencer is idle");

endmodule

bind npu_seq_fsm npu_properties i_npu_properties (
    .aclk      (aclk),
    .rst_n     (rst_n),
    .state     (state),
    .busy      (busy),
    .run_done  (run_done),
    .out_wr_en (out_wr_en)
);

// ==== logic/npu_top.sv ====
// npu top level
// 8x8 matrix-vector product with activation, loaded and read over a
// simple strobe register bus
`timescale 1ns/10ps
`include "npu_settings.svh"

module npu_top (
    input  logic                       aclk,
    input  logic                       rst_n,
    input  logic                       reg_wr,
    input  logic                       reg_rd,
    input  logic [`NPU_REG_ADDR_W-1:0] reg_addr,
    input  logic [`NPU_DATA_W-1:0]     reg_wdata,
    output logic [`NPU_DATA_W-1:0]     reg_rdata,
    output logic                       reg_rvalid,
    output logic                       interrupt
);
    import npu_pkg::*;

    localparam int idx_w = $clog2(`NPU_DIM);

    // ============================================================
    // host side
    // ============================================================
    logic                   start;
    logic                   run_done;
    logic                   busy;
    act_type_t              act_sel;
    logic                   in_wr_en;
    logic [idx_w-1:0]       in_wr_addr;
    logic                   wt_wr_en;
    logic [2*idx_w-1:0]     wt_wr_addr;
    logic [`NPU_DATA_W-1:0] wr_data;
    logic [idx_w-1:0]       out_rd_addr;
    logic [`NPU_DATA_W-1:0] out_rd_data;

    // ============================================================
    // run datapath
    // ============================================================
    logic                   cnt_en;
    logic                   cnt_clr;
    logic [2*idx_w-1:0]     k;
    logic [idx_w-1:0]       row;
    logic [idx_w-1:0]       col;
    logic                   row_first;
    logic                   row_last;
    logic                   last;
    logic                   acc_first;
    logic                   out_wr_en;
    logic [idx_w-1:0]       out_wr_addr;
    logic [`NPU_DATA_W-1:0] in_rd_data;
    logic [`NPU_DATA_W-1:0] wt_rd_data;
    acc_word_t              acc;
    logic [`NPU_DATA_W-1:0] act_result;

    npu_reg_bank i_reg_bank (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .reg_wr      (reg_wr),
        .reg_rd      (reg_rd),
        .reg_addr    (reg_addr),
        .reg_wdata   (reg_wdata),
        .reg_rdata   (reg_rdata),
        .reg_rvalid  (reg_rvalid),
        .start       (start),
        .act_sel     (act_sel),
        .run_done    (run_done),
        .busy        (busy),
        .interrupt   (interrupt),
        .in_wr_en    (in_wr_en),
        .in_wr_addr  (in_wr_addr),
        .wt_wr_en    (wt_wr_en),
        .wt_wr_addr  (wt_wr_addr),
        .wr_data     (wr_data),
        .out_rd_addr (out_rd_addr),
        .out_rd_data (out_rd_data)
    );

    npu_seq_fsm i_seq_fsm (
        .aclk        (aclk),
        .rst_n       (rst_n),
        .start       (start),
        .row_first   (row_first),
        .row_last    (row_last),
        .last        (last),
        .row         (row),
        .cnt_en      (cnt_en),
        .cnt_clr     (cnt_clr),
        .acc_first   (acc_first),
        .out_wr_en   (out_wr_en),
        .out_wr_addr (out_wr_addr),
        .busy        (busy),
        .run_done    (run_done)
    );

    npu_index_counter i_index_counter (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .en        (cnt_en),
        .clr       (cnt_clr),
        .k         (k),
        .row       (row),
        .col       (col),
        .row_first (row_first),
        .row_last  (row_last),
        .last      (last)
    );

    // input vector, addressed by column
    npu_buffer #(.depth(`NPU_DIM)) i_input_buffer (
        .aclk    (aclk),
        .wr_en   (in_wr_en),
        .wr_addr (in_wr_addr),
        .wr_data (wr_data),
        .rd_addr (col),
        .rd_data (in_rd_data)
    );

    // weights, addressed by the linear index
    npu_buffer #(.depth(`NPU_DIM * `NPU_DIM)) i_weight_buffer (
        .aclk    (aclk),
        .wr_en   (wt_wr_en),
        .wr_addr (wt_wr_addr),
        .wr_data (wr_data),
        .rd_addr (k),
        .rd_data (wt_rd_data)
    );

    npu_buffer #(.depth(`NPU_DIM)) i_output_buffer (
        .aclk    (aclk),
        .wr_en   (out_wr_en),
        .wr_addr (out_wr_addr),
        .wr_data (act_result),
        .rd_addr (out_rd_addr),
        .rd_data (out_rd_data)
    );

    npu_mac_unit i_mac_unit (
        .aclk      (aclk),
        .rst_n     (rst_n),
        .acc_first (acc_first),
        .a         (wt_rd_data),
        .b         (in_rd_data),
        .acc       (acc)
    );

    npu_activation i_activation (
        .act_sel (act_sel),
        .acc     (acc),
        .result  (act_result)
    );

endmodule

// ==== logic/npu_seq_fsm.sv ====
// run sequencer
// steps the index counter through all 64 products, lines up row flags
// with the buffer and MAC latency and pulses run_done after the drain
`timescale 1ns/10ps

module npu_seq_fsm (
    input  logic       aclk,
    input  logic       rst_n,
    input  logic       start,
    input  logic       row_first,
    input  logic       row_last,
    input  logic       last,
    input  logic [2:0] row,
    output logic       cnt_en,
    output logic       cnt_clr,
    output logic       acc_first,
    output logic       out_wr_en,
    output logic [2:0] out_wr_addr,
    output logic       busy,
    output logic       run_done
);
    import npu_pkg::*;

    seq_state_t state;
    logic       drain_cnt;
    logic       wr_d1;
    logic [2:0] row_d1;

    // ============================================================
    // state register
    // ============================================================
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            state     <= seq_idle;
            drain_cnt <= 1'b0;
        end else begin
            case (state)
                seq_idle: begin
                    drain_cnt <= 1'b0;
                    if (start) begin
                        state <= seq_mac;
                    end
                end
                seq_mac: begin
                    if (last) begin
                        state <= seq_drain;
                    end
                end
                seq_drain: begin
                    // two cycles for the buffer read and the MAC register
                    drain_cnt <= ~drain_cnt;
                    if (drain_cnt) begin
                        state <= seq_idle;
                    end
                end
                default: state <= seq_idle;
            endcase
        end
    end

    assign cnt_en   = (state == seq_mac);
    assign cnt_clr  = (state == seq_idle);
    assign busy     = (state != seq_idle);
    assign run_done = (state == seq_drain) && drain_cnt;

    // ============================================================
    // flag alignment
    // ============================================================
    // row start meets its operands one cycle later, row end meets
    // the finished accumulator two cycles later
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            acc_first <= 1'b0;
            wr_d1     <= 1'b0;
            out_wr_en <= 1'b0;
        end else begin
            acc_first <= row_first && cnt_en;
            wr_d1     <= row_last && cnt_en;
            out_wr_en <= wr_d1;
        end
    end

    always_ff @(posedge aclk) begin
        row_d1      <= row;
        out_wr_addr <= row_d1;
    end

endmodule

// ==== logic/npu_reg_bank.sv ====
// register bank
// decodes host accesses, routes buffer writes, holds the activation
// select and the done flag, returns read data one cycle after the strobe
`timescale 1ns/10ps
`include "npu_settings.svh"

module npu_reg_bank (
    input  logic                           aclk,
    input  logic                           rst_n,
    input  logic                           reg_wr,
    input  logic                           reg_rd,
    input  logic [`NPU_REG_ADDR_W-1:0]     reg_addr,
    input  logic [`NPU_DATA_W-1:0]         reg_wdata,
    output logic [`NPU_DATA_W-1:0]         reg_rdata,
    output logic                           reg_rvalid,
    output logic                           start,
    output npu_pkg::act_type_t             act_sel,
    input  logic                           run_done,
    input  logic                           busy,
    output logic                           interrupt,
    output logic                           in_wr_en,
    output logic [$clog2(`NPU_DIM)-1:0]    in_wr_addr,
    output logic                           wt_wr_en,
    output logic [2*$clog2(`NPU_DIM)-1:0]  wt_wr_addr,
    output logic [`NPU_DATA_W-1:0]         wr_data,
    output logic [$clog2(`NPU_DIM)-1:0]    out_rd_addr,
    input  logic [`NPU_DATA_W-1:0]         out_rd_data
);
    import npu_pkg::*;

    localparam int idx_w  = $clog2(`NPU_DIM);
    localparam int addr_w = `NPU_REG_ADDR_W;
    localparam logic [addr_w-1:0] input_base  = `NPU_BASE_INPUT;
    localparam logic [addr_w-1:0] output_base = `NPU_BASE_OUTPUT;
    localparam logic [addr_w-1:0] weight_base = `NPU_BASE_WEIGHT;

    logic                   ctrl_wr;
    logic                   input_hit;
    logic                   output_hit;
    logic                   weight_hit;
    logic                   done;
    logic                   rd_out_q;
    logic [`NPU_DATA_W-1:0] status;
    logic [`NPU_DATA_W-1:0] stat_q;

    // ============================================================
    // address decode
    // ============================================================
    assign input_hit  = reg_addr[addr_w-1:idx_w] == input_base[addr_w-1:idx_w];
    assign output_hit = reg_addr[addr_w-1:idx_w] == output_base[addr_w-1:idx_w];
    assign weight_hit = reg_addr[addr_w-1:2*idx_w] == weight_base[addr_w-1:2*idx_w];
    assign ctrl_wr    = reg_wr && (reg_addr == `NPU_ADDR_CTRL);

    // buffer writes go straight through, index from the low address bits
    assign in_wr_en    = reg_wr && input_hit;
    assign in_wr_addr  = reg_addr[idx_w-1:0];
    assign wt_wr_en    = reg_wr && weight_hit;
    assign wt_wr_addr  = reg_addr[2*idx_w-1:0];
    assign wr_data     = reg_wdata;
    assign out_rd_addr = reg_addr[idx_w-1:0];

    // bit 0 of the control word launches a run
    assign start = ctrl_wr && reg_wdata[0];

    // ============================================================
    // control and done flag
    // ============================================================
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            act_sel <= act_identity;
            done    <= 1'b0;
        end else begin
            // activation is frozen for the length of a run
            if (ctrl_wr && !busy) begin
                act_sel <= act_type_t'(reg_wdata[2:1]);
            end
            if (run_done) begin
                done <= 1'b1;
            end else if (start && !busy) begin
                done <= 1'b0;
            end
        end
    end

    assign interrupt = done;
    assign status    = {{(`NPU_DATA_W-2){1'b0}}, done, busy};

    // ============================================================
    // read path
    // ============================================================
    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            reg_rvalid <= 1'b0;
            rd_out_q   <= 1'b0;
        end else begin
            reg_rvalid <= reg_rd;
            rd_out_q   <= reg_rd && output_hit;
        end
    end

    // status snapshot, zero for unmapped addresses
    always_ff @(posedge aclk) begin
        if (reg_rd) begin
            stat_q <= (reg_addr == `NPU_ADDR_STATUS) ? status : '0;
        end
    end

    // output buffer data is already registered by the memory
    assign reg_rdata = rd_out_q ? out_rd_data : stat_q;

endmodule

// ==== logic/npu_activation.sv ====
// activation stage
// identity, relu or step on the Q16.16 accumulator, then reduction
// to Q8.8 with saturation
`timescale 1ns/10ps
`include "npu_settings.svh"

module npu_activation (
    input  npu_pkg::act_type_t     act_sel,
    input  npu_pkg::acc_word_t     acc,
    output logic [`NPU_DATA_W-1:0] result
);
    import npu_pkg::*;

    // 1.0 in Q16.16
    localparam logic [`NPU_ACC_W-1:0] acc_one = 1 << (2 * `NPU_FRAC_BITS);
    localparam logic [`NPU_DATA_W-1:0] sat_max = {1'b0, {(`NPU_DATA_W-1){1'b1}}};
    localparam logic [`NPU_DATA_W-1:0] sat_min = {1'b1, {(`NPU_DATA_W-1){1'b0}}};

    acc_word_t shaped;
    logic      overflow;

    always_comb begin
        shaped = acc;
        case (act_sel)
            act_relu: begin
                if (acc.raw[`NPU_ACC_W-1]) begin
                    shaped.raw = '0;
                end
            end
            act_step: begin
                shaped.raw = (!acc.raw[`NPU_ACC_W-1] && acc.raw != '0) ? acc_one : '0;
            end
            // spare code falls through as identity
            default: shaped = acc;
        endcase
    end

    // overflow byte must be the sign extension of the Q8.8 field
    assign overflow = shaped.f.sat_hi != {$bits(shaped.f.sat_hi){shaped.f.q8_8[`NPU_DATA_W-1]}};

    assign result = !overflow ? shaped.f.q8_8 :
                    shaped.raw[`NPU_ACC_W-1] ? sat_min : sat_max;

endmodule

// ==== logic/npu_mac_unit.sv ====
// multiply-accumulate unit
// signed Q8.8 x Q8.8 into a wrapping Q16.16 accumulator,
// reloaded at the first element of each row
`timescale 1ns/10ps
`include "npu_settings.svh"

module npu_mac_unit (
    input  logic                   aclk,
    input  logic                   rst_n,
    input  logic                   acc_first,
    input  logic [`NPU_DATA_W-1:0] a,
    input  logic [`NPU_DATA_W-1:0] b,
    output npu_pkg::acc_word_t     acc
);
    logic signed [`NPU_ACC_W-1:0] product;

    // both operands sign-extend to the full accumulator width
    assign product = $signed(a) * $signed(b);

    always_ff @(posedge aclk) begin
        if (!rst_n) begin
            acc.raw <= '0;
        end else if (acc_first) begin
            acc.raw <= product;
        end else begin
            // wraps on overflow, saturation happens downstream
            acc.raw <= acc.raw + product;
        end
    end

endmodule

// ==== logic/npu_index_counter.sv ====
// index counter
// linear element index k with row and column as its upper and lower fields
`timescale 1ns/10ps
`include "npu_settings.svh"

module npu_index_counter (
    input  logic                          aclk,
    input  logic                          rst_n,
    input  logic                          en,
    input  logic                          clr,
    output logic [2*$clog2(`NPU_DIM)-1:0] k,
    output logic [$clog2(`NPU_DIM)-1:0]   row,
    output logic [$clog2(`NPU_DIM)-1:0]   col,
    output logic                          row_first,
    output logic                          row_last,
    output logic                          last
);
    localparam int idx_w = $clog2(`NPU_DIM);

    always_ff @(posedge aclk) begin
        if (!rst_n || clr) begin
            k <= '0;
        end else if (en) begin
            k <= k + 1'b1;
        end
    end

    assign row = k[2*idx_w-1:idx_w];
    assign col = k[idx_w-1:0];

    // end flags straight from the count
    assign row_first = (col == '0);
    assign row_last  = (col == idx_w'(`NPU_DIM - 1));
    assign last      = (k == (2*idx_w)'(`NPU_DIM * `NPU_DIM - 1));

endmodule

// ==== logic/npu_buffer.sv ====
// buffer memory
// single write port, registered read port, contents not reset
`timescale 1ns/10ps
`include "npu_settings.svh"

module npu_buffer #(
    parameter int depth = 8
) (
    input  logic                     aclk,
    input  logic                     wr_en,
    input  logic [$clog2(depth)-1:0] wr_addr,
    input  logic [`NPU_DATA_W-1:0]   wr_data,
    input  logic [$clog2(depth)-1:0] rd_addr,
    output logic [`NPU_DATA_W-1:0]   rd_data
);
    logic [`NPU_DATA_W-1:0] mem [depth];

    always_ff @(posedge aclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
        // read returns the old word on a same-address write
        rd_data <= mem[rd_addr];
    end

endmodule

// ==== logic/npu_pkg.sv ====
// npu package
// accumulator word with its two views, activation and run-state encodings
`include "npu_settings.svh"

package npu_pkg;

    // Q16.16 accumulator split into overflow byte, Q8.8 result and dropped fraction
    typedef struct packed {
        logic [`NPU_ACC_W-`NPU_DATA_W-`NPU_FRAC_BITS-1:0] sat_hi;
        logic [`NPU_DATA_W-1:0]                          q8_8;
        logic [`NPU_FRAC_BITS-1:0]                       frac_lo;
    } acc_fields_t;

    typedef union packed {
        logic [`NPU_ACC_W-1:0] raw;
        acc_fields_t           f;
    } acc_word_t;

    // control register bits 2:1
    typedef enum logic [1:0] {
        act_identity = 2'd0,
        act_relu     = 2'd1,
        act_step     = 2'd2,
        act_spare    = 2'd3
    } act_type_t;

    typedef enum logic [1:0] {
        seq_idle  = 2'd0,
        seq_mac   = 2'd1,
        seq_drain = 2'd2
    } seq_state_t;

endpackage

// ==== logic/npu_settings.svh ====
// npu settings
// matrix dimension, datapath widths and the host register map
`ifndef NPU_SETTINGS_SVH
`define NPU_SETTINGS_SVH

// datapath
`define NPU_DIM             8
`define NPU_DATA_W          16
`define NPU_ACC_W           32
`define NPU_FRAC_BITS       8

// register map, one 16-bit word per address
`define NPU_REG_ADDR_W      8
`define NPU_ADDR_CTRL       8'h00
`define NPU_ADDR_STATUS     8'h01
`define NPU_BASE_INPUT      8'h10
`define NPU_BASE_OUTPUT     8'h20
// weights are row-major, 64 words
`define NPU_BASE_WEIGHT     8'h40

`endif
